// File: design/event_framer.sv
`timescale 1ns/100ps

module event_framer import hist_geom_pkg::*; #(
    parameter int PIXELS = 4,
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQS = 2
) (
    input  logic     clk,
    input  logic     res,
    input  logic     in_req,
    input  bin_idx_t in_bin,
    input  logic     bank_busy,
    output logic     in_ack,
    output logic     inc_en,
    output pix_idx_t inc_pixel,
    output bin_idx_t inc_bin,
    output logic     frame_done
);

    // counter widths, at least one bit each
    localparam int EW = (EVENTS_PER_PIXEL > 1) ? $clog2(EVENTS_PER_PIXEL) : 1;
    localparam int QW = (ACQS > 1) ? $clog2(ACQS) : 1;

    localparam logic [EW-1:0] EV_LAST = EW'(EVENTS_PER_PIXEL - 1);
    localparam pix_idx_t PIX_LAST = pix_idx_t'(PIXELS - 1);
    localparam logic [QW-1:0] ACQ_LAST = QW'(ACQS - 1);

    logic [EW-1:0] ev_cnt;
    pix_idx_t      pix_cnt;
    logic [QW-1:0] acq_cnt;

    // first cycle out of reset, before bank_busy shows the clear walk
    logic started;
    logic stall;
    logic accept;

    // no new event while a finished frame waits for its swap
    assign stall = !started || frame_done || bank_busy;

    // new request, previous handshake closed
    assign accept = in_req && !in_ack && !stall;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            started    <= 1'b0;
            in_ack     <= 1'b0;
            inc_en     <= 1'b0;
            frame_done <= 1'b0;
            ev_cnt     <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
        end else begin
            started    <= 1'b1;
            inc_en     <= 1'b0;
            frame_done <= 1'b0;
            if (in_ack) begin
                // release once the requester has let go
                if (!in_req) begin
                    in_ack <= 1'b0;
                end
            end else if (accept) begin
                in_ack <= 1'b1;
                inc_en <= 1'b1;
                // events inside pixel, pixels inside acquisition
                if (ev_cnt == EV_LAST) begin
                    ev_cnt <= '0;
                    if (pix_cnt == PIX_LAST) begin
                        pix_cnt <= '0;
                        if (acq_cnt == ACQ_LAST) begin
                            acq_cnt    <= '0;
                            // last event of the frame
                            frame_done <= 1'b1;
                        end else begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end else begin
                    ev_cnt <= ev_cnt + 1'b1;
                end
            end
        end
    end

    // increment target, valid with inc_en
    always_ff @(posedge clk) begin
        if (accept) begin
            inc_pixel <= pix_cnt;
            inc_bin   <= in_bin;
        end
    end

endmodule

// File: design/hist_bank.sv
`timescale 1ns/100ps

module hist_bank import hist_geom_pkg::*; #(
    parameter int PIXELS = 4
) (
    input  logic     clk,
    input  logic     res,
    input  logic     inc_en,
    input  pix_idx_t inc_pixel,
    input  bin_idx_t inc_bin,
    input  logic     frame_done,
    input  logic     rd_en,
    input  pix_idx_t rd_pixel,
    input  bin_idx_t rd_bin,
    input  logic     drain_done,
    output logic     bank_busy,
    output logic     drain_start,
    output count_t   rd_count,
    output logic     fill_bank
);

    // pixel bits actually used to address the array
    localparam int PW = (PIXELS > 1) ? $clog2(PIXELS) : 1;

    // two banks of PIXELS histograms
    count_t mem [2][PIXELS][NUM_BINS];

    logic     drain_bank;
    // drain bank still holds an unread frame
    logic     drain_busy;
    logic     clr_active;
    pix_idx_t clr_pix;
    bin_idx_t clr_bin;

    assign drain_bank = ~fill_bank;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clr_active  <= 1'b1;
            clr_pix     <= '0;
            clr_bin     <= '0;
            fill_bank   <= 1'b0;
            drain_busy  <= 1'b0;
            bank_busy   <= 1'b0;
            drain_start <= 1'b0;
        end else begin
            drain_start <= 1'b0;
            if (clr_active) begin
                // hold the framer off during the walk
                bank_busy <= 1'b1;
                if (clr_bin == bin_idx_t'(NUM_BINS - 1)) begin
                    clr_bin <= '0;
                    if (clr_pix == pix_idx_t'(PIXELS - 1)) begin
                        clr_active <= 1'b0;
                        bank_busy  <= 1'b0;
                    end else begin
                        clr_pix <= clr_pix + 1'b1;
                    end
                end else begin
                    clr_bin <= clr_bin + 1'b1;
                end
            end else begin
                if (drain_done) begin
                    drain_busy <= 1'b0;
                end
                // frame finished now or still pending
                if (frame_done || bank_busy) begin
                    if (!drain_busy || drain_done) begin
                        fill_bank   <= ~fill_bank;
                        drain_start <= 1'b1;
                        drain_busy  <= 1'b1;
                        bank_busy   <= 1'b0;
                    end else begin
                        bank_busy <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clr_active) begin
            mem[0][clr_pix[PW-1:0]][clr_bin] <= '0;
            mem[1][clr_pix[PW-1:0]][clr_bin] <= '0;
        end else begin
            // read-modify-write on the filling bank
            if (inc_en) begin
                mem[fill_bank][inc_pixel[PW-1:0]][inc_bin] <=
                    mem[fill_bank][inc_pixel[PW-1:0]][inc_bin] + 1'b1;
            end
            // clear on read, other bank
            if (rd_en) begin
                rd_count <= mem[drain_bank][rd_pixel[PW-1:0]][rd_bin];
                mem[drain_bank][rd_pixel[PW-1:0]][rd_bin] <= '0;
            end
        end
    end

endmodule

// File: design/hist_geom_pkg.sv
package hist_geom_pkg;

    // histogram geometry, shared by framer, bank and readout

    // bins per pixel histogram
    localparam int BIN_W = 6;
    localparam int NUM_BINS = 64;

    // pixel index width, up to 16 pixels
    localparam int PIX_W = 4;

    // one bin counter, wraps on overflow
    localparam int CNT_W = 16;

    // bin index of an incoming event
    typedef logic [BIN_W-1:0] bin_idx_t;

    // pixel index inside one frame
    typedef logic [PIX_W-1:0] pix_idx_t;

    // accumulated count of one bin
    typedef logic [CNT_W-1:0] count_t;

endpackage

// File: design/hist_out_pkg.sv
package hist_out_pkg;

    import hist_geom_pkg::*;

    // frame sequence number, counted by the readout
    typedef logic [7:0] frame_t;

    // what the current output word carries
    typedef enum logic {
        kind_header = 1'b0,
        kind_count  = 1'b1
    } word_kind_t;

    // header word: one per pixel, ahead of its counts
    typedef struct packed {
        frame_t     frame;
        pix_idx_t   pixel;
        logic       bank;
        logic [10:0] pad;
    } hdr_view_t;

    // count word: one per bin
    typedef struct packed {
        bin_idx_t   bin;
        logic [1:0] pad;
        count_t     count;
    } cnt_view_t;

    // 24 bit output word, decoded by out_kind
    typedef union packed {
        hdr_view_t hdr;
        cnt_view_t cnt;
    } out_word_u;

endpackage

// File: design/hist_readout.sv
`timescale 1ns/100ps

module hist_readout import hist_geom_pkg::*, hist_out_pkg::*; #(
    parameter int PIXELS = 4
) (
    input  logic       clk,
    input  logic       res,
    input  logic       drain_start,
    input  logic       fill_bank,
    input  count_t     rd_count,
    input  logic       out_ack,
    output logic       rd_en,
    output pix_idx_t   rd_pixel,
    output bin_idx_t   rd_bin,
    output logic       drain_done,
    output logic       out_req,
    output out_word_u  out_word,
    output word_kind_t out_kind
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND,
        S_REL,
        S_READ,
        S_LATCH
    } state_t;

    state_t state;
    frame_t frame_cnt;

    function automatic out_word_u make_hdr(frame_t frame, pix_idx_t pixel, logic bank);
        out_word_u w;
        w.hdr.frame = frame;
        w.hdr.pixel = pixel;
        w.hdr.bank  = bank;
        w.hdr.pad   = '0;
        return w;
    endfunction

    function automatic out_word_u make_cnt(bin_idx_t bin, count_t count);
        out_word_u w;
        w.cnt.bin   = bin;
        w.cnt.pad   = '0;
        w.cnt.count = count;
        return w;
    endfunction

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= S_IDLE;
            frame_cnt  <= '0;
            rd_en      <= 1'b0;
            rd_pixel   <= '0;
            rd_bin     <= '0;
            drain_done <= 1'b0;
            out_req    <= 1'b0;
        end else begin
            rd_en      <= 1'b0;
            drain_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (drain_start) begin
                        rd_pixel <= '0;
                        rd_bin   <= '0;
                        out_req  <= 1'b1;
                        state    <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= S_REL;
                    end
                end
                S_REL: begin
                    // wait for ack low, then pick the next word
                    if (!out_ack) begin
                        if (out_kind == kind_header) begin
                            rd_en <= 1'b1;
                            state <= S_READ;
                        end else if (rd_bin != bin_idx_t'(NUM_BINS - 1)) begin
                            rd_bin <= rd_bin + 1'b1;
                            rd_en  <= 1'b1;
                            state  <= S_READ;
                        end else if (rd_pixel != pix_idx_t'(PIXELS - 1)) begin
                            // header of the next pixel
                            rd_pixel <= rd_pixel + 1'b1;
                            rd_bin   <= '0;
                            out_req  <= 1'b1;
                            state    <= S_SEND;
                        end else begin
                            frame_cnt  <= frame_cnt + 1'b1;
                            drain_done <= 1'b1;
                            state      <= S_IDLE;
                        end
                    end
                end
                S_READ: begin
                    // bank answers one cycle after rd_en
                    state <= S_LATCH;
                end
                S_LATCH: begin
                    out_req <= 1'b1;
                    state   <= S_SEND;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // output word, held while out_req is high
    always_ff @(posedge clk) begin
        if ((state == S_IDLE && drain_start) ||
            (state == S_REL && !out_ack && out_kind == kind_count &&
             rd_bin == bin_idx_t'(NUM_BINS - 1))) begin
            // header carries the drained bank id
            out_word <= make_hdr(frame_cnt,
                                 (state == S_IDLE) ? '0 : rd_pixel + 1'b1,
                                 ~fill_bank);
            out_kind <= kind_header;
        end else if (state == S_LATCH) begin
            out_word <= make_cnt(rd_bin, rd_count);
            out_kind <= kind_count;
        end
    end

endmodule

// File: design/hist_top.sv
`timescale 1ns/100ps

module hist_top import hist_geom_pkg::*, hist_out_pkg::*; #(
    parameter int PIXELS = 4,
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQS = 2
) (
    input  logic       clk,
    input  logic       res,
    input  logic       in_req,
    input  bin_idx_t   in_bin,
    input  logic       out_ack,
    output logic       in_ack,
    output logic       out_req,
    output out_word_u  out_word,
    output word_kind_t out_kind
);

    // framer to bank
    logic     inc_en;
    pix_idx_t inc_pixel;
    bin_idx_t inc_bin;
    logic     frame_done;
    logic     bank_busy;

    // bank to readout
    logic     drain_start;
    logic     drain_done;
    logic     fill_bank;
    logic     rd_en;
    pix_idx_t rd_pixel;
    bin_idx_t rd_bin;
    count_t   rd_count;

    event_framer #(
        .PIXELS(PIXELS),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQS(ACQS)
    ) u_framer (
        .clk(clk),
        .res(res),
        .in_req(in_req),
        .in_bin(in_bin),
        .bank_busy(bank_busy),
        .in_ack(in_ack),
        .inc_en(inc_en),
        .inc_pixel(inc_pixel),
        .inc_bin(inc_bin),
        .frame_done(frame_done)
    );

    hist_bank #(
        .PIXELS(PIXELS)
    ) u_bank (
        .clk(clk),
        .res(res),
        .inc_en(inc_en),
        .inc_pixel(inc_pixel),
        .inc_bin(inc_bin),
        .frame_done(frame_done),
        .rd_en(rd_en),
        .rd_pixel(rd_pixel),
        .rd_bin(rd_bin),
        .drain_done(drain_done),
        .bank_busy(bank_busy),
        .drain_start(drain_start),
        .rd_count(rd_count),
        .fill_bank(fill_bank)
    );

    // drains the bank that was just swapped out
    hist_readout #(
        .PIXELS(PIXELS)
    ) u_readout (
        .clk(clk),
        .res(res),
        .drain_start(drain_start),
        .fill_bank(fill_bank),
        .rd_count(rd_count),
        .out_ack(out_ack),
        .rd_en(rd_en),
        .rd_pixel(rd_pixel),
        .rd_bin(rd_bin),
        .drain_done(drain_done),
        .out_req(out_req),
        .out_word(out_word),
        .out_kind(out_kind)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# compile and run the histogram testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_hist -f src.f -o sim_hist
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

# keep running after an assertion error so the testbench reports it
./obj_dir/sim_hist +verilator+error+limit+100
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit 1
fi

echo "simulation finished"
exit 0

// File: src.f
design/hist_geom_pkg.sv
design/hist_out_pkg.sv
design/event_framer.sv
design/hist_bank.sv
design/hist_readout.sv
design/hist_top.sv
tests/hist_props.sv
tests/tb_hist.sv

// File: tests/hist_props.sv
`timescale 1ns/100ps

module hist_props import hist_geom_pkg::*, hist_out_pkg::*; (
    input logic      clk,
    input logic      res,
    input logic      in_req,
    input bin_idx_t  in_bin,
    input logic      in_ack,
    input logic      inc_en,
    input logic      out_req,
    input logic      out_ack,
    input out_word_u out_word,
    input logic      drain_start,
    input logic      fill_bank
);

    // failed assertions so far, polled by the testbench
    int unsigned fails = 0;

    // event bin held through the whole request phase
    in_bin_stable: assert property (@(posedge clk) disable iff (!res)
        in_req && $past(in_req) |-> $stable(in_bin))
        else begin
            $error("in_bin changed while in_req was high");
            fails++;
        end

    // output word held until out_req drops
    out_word_stable: assert property (@(posedge clk) disable iff (!res)
        out_req && $past(out_req) |-> $stable(out_word))
        else begin
            $error("out_word changed while out_req was high");
            fails++;
        end

    // new output request only after the old ack is gone
    out_req_after_ack: assert property (@(posedge clk) disable iff (!res)
        !out_req && out_ack |=> !out_req)
        else begin
            $error("out_req rose while out_ack was still high");
            fails++;
        end

    // one increment per handshake, never inside an open one
    inc_on_new_ack: assert property (@(posedge clk) disable iff (!res)
        inc_en |-> !$past(in_ack))
        else begin
            $error("inc_en fired while in_ack was already high");
            fails++;
        end

    // a swap hands the finished bank to an idle readout
    swap_when_idle: assert property (@(posedge clk) disable iff (!res)
        fill_bank != $past(fill_bank) |-> drain_start && !out_req)
        else begin
            $error("bank swap while the readout was still sending");
            fails++;
        end

endmodule

// File: tests/tb_hist.sv
`timescale 1ns/100ps

module tb_hist import hist_geom_pkg::*, hist_out_pkg::*; #(
    parameter int PIXELS = 4,
    parameter int EVENTS_PER_PIXEL = 8,
    parameter int ACQS = 2,
    parameter int NUM_FRAMES = 3
);

    localparam int EVENTS_PER_ACQ = PIXELS * EVENTS_PER_PIXEL;
    localparam int EVENTS_PER_FRAME = EVENTS_PER_ACQ * ACQS;
    localparam int WORDS_PER_FRAME = PIXELS * (NUM_BINS + 1);
    localparam int CLEAR_CYCLES = PIXELS * NUM_BINS;
    // 8 cycles per event, 10 per word, clear walk, then twice that
    localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * (EVENTS_PER_FRAME * 8 +
                                    WORDS_PER_FRAME * 10) + CLEAR_CYCLES);
    // drained with the slowest ack while the second frame fills
    localparam int SLOW_FRAME = 0;

    logic       clk;
    logic       res;
    logic       in_req;
    bin_idx_t   in_bin;
    logic       out_ack;
    logic       in_ack;
    logic       out_req;
    out_word_u  out_word;
    word_kind_t out_kind;

    integer      seed;
    // own stream for the output responder
    integer      ack_seed;
    int unsigned cycles;
    int unsigned run_cycles;
    int          frames_sent;
    int          frames_rcvd;

    // reference histograms, frame by pixel by bin
    count_t exp_hist [NUM_FRAMES][PIXELS][NUM_BINS];

    hist_top #(
        .PIXELS(PIXELS),
        .EVENTS_PER_PIXEL(EVENTS_PER_PIXEL),
        .ACQS(ACQS)
    ) DUT (
        .clk(clk),
        .res(res),
        .in_req(in_req),
        .in_bin(in_bin),
        .out_ack(out_ack),
        .in_ack(in_ack),
        .out_req(out_req),
        .out_word(out_word),
        .out_kind(out_kind)
    );

    bind hist_top hist_props props (
        .clk(clk),
        .res(res),
        .in_req(in_req),
        .in_bin(in_bin),
        .in_ack(in_ack),
        .inc_en(inc_en),
        .out_req(out_req),
        .out_ack(out_ack),
        .out_word(out_word),
        .drain_start(drain_start),
        .fill_bank(fill_bank)
    );

    always #50 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    function automatic string mismatch_line(input string name, input logic [31:0] exp,
                                            input logic [31:0] got);
        return $sformatf("[ERROR] at time %0t: %s expected 0x%0h, got 0x%0h",
                         $time, name, exp, got);
    endfunction

    // cycle budget, counted from time zero
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (res) begin
            run_cycles <= run_cycles + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: not all output words arrived in time");
        end
    end

    // watch for assertion failures and early handshakes
    always @(negedge clk) begin
        if (DUT.props.fails != 0) begin
            stop_with_failure("a bound assertion failed, see the error above");
        end else if (in_ack && run_cycles <= CLEAR_CYCLES) begin
            stop_with_failure("in_ack rose before the clear walk had ended");
        end else if (out_req && frames_sent <= frames_rcvd) begin
            stop_with_failure("out_req rose before its frame was complete");
        end
    end

    task automatic check_kind(input word_kind_t got, input word_kind_t exp);
        if (got !== exp) begin
            stop_with_failure(mismatch_line("out_kind", 32'(exp), 32'(got)));
        end
    endtask

    task automatic check_header(input out_word_u got, input out_word_u exp);
        if (got.hdr.frame !== exp.hdr.frame) begin
            stop_with_failure(mismatch_line("out_word.hdr.frame",
                                            32'(exp.hdr.frame), 32'(got.hdr.frame)));
        end else if (got.hdr.pixel !== exp.hdr.pixel) begin
            stop_with_failure(mismatch_line("out_word.hdr.pixel",
                                            32'(exp.hdr.pixel), 32'(got.hdr.pixel)));
        end else if (got.hdr.bank !== exp.hdr.bank) begin
            stop_with_failure(mismatch_line("out_word.hdr.bank",
                                            32'(exp.hdr.bank), 32'(got.hdr.bank)));
        end
    endtask

    task automatic check_count(input bin_idx_t got_bin, input count_t got_count,
                               input bin_idx_t exp_bin, input count_t exp_count);
        if (got_bin !== exp_bin) begin
            stop_with_failure(mismatch_line("out_word.cnt.bin", 32'(exp_bin), 32'(got_bin)));
        end else if (got_count !== exp_count) begin
            stop_with_failure(mismatch_line("out_word.cnt.count",
                                            32'(exp_count), 32'(got_count)));
        end
    endtask

    // one four-phase input transfer
    task automatic send_event(input bin_idx_t bin, input logic last_of_frame,
                              output int rcvd_at_ack);
        in_bin = bin;
        in_req = 1'b1;
        @(negedge clk);
        while (!in_ack) begin
            @(negedge clk);
        end
        rcvd_at_ack = frames_rcvd;
        if (last_of_frame) begin
            frames_sent++;
        end
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic send_frames();
        bin_idx_t bin;
        pix_idx_t pix;
        int       gap;
        int       rcvd_at_ack;
        int       f;
        int       a;
        int       k;
        for (f = 0; f < NUM_FRAMES; f++) begin
            for (a = 0; a < ACQS; a++) begin
                for (k = 0; k < EVENTS_PER_ACQ; k++) begin
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) @(negedge clk);
                    bin = bin_idx_t'($random(seed));
                    // event order picks the pixel
                    pix = pix_idx_t'(k / EVENTS_PER_PIXEL);
                    exp_hist[f][pix][bin] = exp_hist[f][pix][bin] + count_t'(1);
                    send_event(bin, a == ACQS - 1 && k == EVENTS_PER_ACQ - 1, rcvd_at_ack);
                    // frame f needs the bank of frame f-2 drained first
                    if (a == 0 && k == 0 && f >= 2 && rcvd_at_ack < f - 1) begin
                        stop_with_failure($sformatf(
                            "frame %0d was accepted before frame %0d had drained", f, f - 2));
                    end
                end
            end
        end
    endtask

    function automatic int ack_delay(input int frame);
        if (frame == SLOW_FRAME) begin
            return 3;
        end
        return $unsigned($random(ack_seed)) % 4;
    endfunction

    // one four-phase output transfer, ack after delay cycles
    task automatic receive_word(input int delay, output out_word_u word,
                                output word_kind_t kind);
        while (!out_req) begin
            @(negedge clk);
        end
        word = out_word;
        kind = out_kind;
        repeat (delay) @(negedge clk);
        out_ack = 1'b1;
        @(negedge clk);
        while (out_req) begin
            @(negedge clk);
        end
        out_ack = 1'b0;
    endtask

    task automatic receive_frames();
        out_word_u  word;
        out_word_u  exp_word;
        word_kind_t kind;
        int         f;
        int         p;
        int         b;
        for (f = 0; f < NUM_FRAMES; f++) begin
            for (p = 0; p < PIXELS; p++) begin
                receive_word(ack_delay(f), word, kind);
                check_kind(kind, kind_header);
                // first frame fills bank 0, then the banks alternate
                exp_word = '0;
                exp_word.hdr.frame = frame_t'(f);
                exp_word.hdr.pixel = pix_idx_t'(p);
                exp_word.hdr.bank = ((f % 2) == 1);
                check_header(word, exp_word);
                for (b = 0; b < NUM_BINS; b++) begin
                    receive_word(ack_delay(f), word, kind);
                    check_kind(kind, kind_count);
                    check_count(word.cnt.bin, word.cnt.count, bin_idx_t'(b), exp_hist[f][p][b]);
                end
            end
            frames_rcvd++;
        end
    endtask

    initial begin
        clk = 1'b0;
        res = 1'b0;
        in_req = 1'b0;
        in_bin = '0;
        out_ack = 1'b0;
        seed = 32'h5f0d;
        ack_seed = 32'h5f0d;
        cycles = 0;
        run_cycles = 0;
        frames_sent = 0;
        frames_rcvd = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            for (int p = 0; p < PIXELS; p++) begin
                for (int b = 0; b < NUM_BINS; b++) begin
                    exp_hist[f][p][b] = '0;
                end
            end
        end
        repeat (8) @(negedge clk);
        res = 1'b1;
        fork
            send_frames();
            receive_frames();
        join
        // output must stay quiet after the last frame
        repeat (20) @(negedge clk);
        if (DUT.props.fails == 0 && !out_req) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_failure($sformatf(
                "run ended with %0d assertion failures or a stray output word",
                DUT.props.fails));
        end
    end

endmodule
